/* list.f */
rv_pkg.sv
rv_register_file.sv
rv_decoder.sv
rv_execute_stage.sv
rv_int_core.sv
tb_clk_gen.sv
tb_rv_int_core.sv

/* rv_decoder.sv */
// ----------------------------------------------------------------------
// Instruction decoder for the integer execute core
// Reads one word in register or immediate layout, picks out register
// numbers, ALU operation and sign-extended immediate
// Unsupported encodings raise illegal_o instead of valid_o
// Purely combinational
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
  input  logic                          instr_valid_i,
  input  instr_u                        instr_i,

  output logic [REGFILE_ADDR_WIDTH-1:0] rs1_o,
  output logic [REGFILE_ADDR_WIDTH-1:0] rs2_o,
  output logic [REGFILE_ADDR_WIDTH-1:0] rd_o,
  output logic [ALU_OP_WIDTH-1:0]       alu_op_o,
  output logic                          use_imm_o,
  output logic [REGFILE_WORD_WIDTH-1:0] imm_o,

  output logic                          valid_o,
  output logic                          illegal_o
);

  logic legal;

  // Register numbers sit at the same place in both layouts
  assign rs1_o = instr_i.r.rs1;
  assign rs2_o = instr_i.r.rs2;
  assign rd_o  = instr_i.r.rd;

  // 12-bit immediate, sign-extended
  assign imm_o = {{(REGFILE_WORD_WIDTH-12){instr_i.i.imm[11]}}, instr_i.i.imm};

  // --------------------------------------------------------------------
  // Operation decode
  // --------------------------------------------------------------------
  always_comb begin
    alu_op_o  = ALU_ADD;
    use_imm_o = 1'b0;
    legal     = 1'b0;

    case (instr_i.r.opcode)
      OPCODE_OP: begin
        // Register form, funct7 picks ADD or SUB and must be base otherwise
        unique case (instr_i.r.funct3)
          FUNCT3_ADD_SUB: begin
            alu_op_o = (instr_i.r.funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
            legal    = (instr_i.r.funct7 == FUNCT7_BASE) ||
                       (instr_i.r.funct7 == FUNCT7_ALT);
          end
          FUNCT3_SLL: begin alu_op_o = ALU_SLL; legal = 1'b1; end
          FUNCT3_SLT: begin alu_op_o = ALU_SLT; legal = 1'b1; end
          FUNCT3_XOR: begin alu_op_o = ALU_XOR; legal = 1'b1; end
          FUNCT3_SRL: begin alu_op_o = ALU_SRL; legal = 1'b1; end
          FUNCT3_OR:  begin alu_op_o = ALU_OR;  legal = 1'b1; end
          FUNCT3_AND: begin alu_op_o = ALU_AND; legal = 1'b1; end
          // SLTU is not supported
          default: legal = 1'b0;
        endcase
        if (instr_i.r.funct3 != FUNCT3_ADD_SUB && instr_i.r.funct7 != FUNCT7_BASE) begin
          legal = 1'b0;
        end
      end

      OPCODE_OP_IMM: begin
        // Immediate form, no shifts and no SLTIU
        use_imm_o = 1'b1;
        case (instr_i.i.funct3)
          FUNCT3_ADD_SUB: begin alu_op_o = ALU_ADD; legal = 1'b1; end
          FUNCT3_SLT:     begin alu_op_o = ALU_SLT; legal = 1'b1; end
          FUNCT3_XOR:     begin alu_op_o = ALU_XOR; legal = 1'b1; end
          FUNCT3_OR:      begin alu_op_o = ALU_OR;  legal = 1'b1; end
          FUNCT3_AND:     begin alu_op_o = ALU_AND; legal = 1'b1; end
          default:        legal = 1'b0;
        endcase
      end

      default: legal = 1'b0;
    endcase
  end

  // Both outcomes only exist while an instruction is presented
  assign valid_o   = instr_valid_i &&  legal;
  assign illegal_o = instr_valid_i && !legal;

  // A presented word is either accepted or flagged, never both
  a_valid_xor_illegal: assert final (!(valid_o && illegal_o));

endmodule

/* rv_execute_stage.sv */
// ----------------------------------------------------------------------
// Execute stage of the integer core
// Forwards the pending writeback to the operands, runs the ALU and
// registers the result, one cycle from valid_i to wb_valid_o
// The registered result drives register file write port 1
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module rv_execute_stage import rv_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,

  // Decoded instruction
  input  logic                          valid_i,
  input  logic [ALU_OP_WIDTH-1:0]       alu_op_i,
  input  logic                          use_imm_i,
  input  logic [REGFILE_WORD_WIDTH-1:0] imm_i,
  input  logic [REGFILE_ADDR_WIDTH-1:0] rs1_i,
  input  logic [REGFILE_ADDR_WIDTH-1:0] rs2_i,
  input  logic [REGFILE_ADDR_WIDTH-1:0] rd_i,

  // Operands from the register file
  input  logic [REGFILE_WORD_WIDTH-1:0] rs1_data_i,
  input  logic [REGFILE_WORD_WIDTH-1:0] rs2_data_i,

  // Writeback
  output logic                          wb_valid_o,
  output logic [REGFILE_ADDR_WIDTH-1:0] wb_rd_o,
  output logic [REGFILE_WORD_WIDTH-1:0] wb_data_o
);

  logic                          fwd_rs1;
  logic                          fwd_rs2;
  logic [REGFILE_WORD_WIDTH-1:0] op_a;
  logic [REGFILE_WORD_WIDTH-1:0] op_b;
  logic [4:0]                    shamt;
  logic [REGFILE_WORD_WIDTH-1:0] alu_result;

  // --------------------------------------------------------------------
  // Operand forwarding
  // --------------------------------------------------------------------
  // wb_valid_o is never set for x0, so x0 is never forwarded
  assign fwd_rs1 = wb_valid_o && (rs1_i == wb_rd_o);
  assign fwd_rs2 = wb_valid_o && (rs2_i == wb_rd_o);

  assign op_a = fwd_rs1 ? wb_data_o : rs1_data_i;

  // Immediate replaces the second register operand
  assign op_b = use_imm_i ? imm_i :
                fwd_rs2   ? wb_data_o : rs2_data_i;

  // Shift amount from the low bits only
  assign shamt = op_b[4:0];

  // --------------------------------------------------------------------
  // ALU
  // --------------------------------------------------------------------
  always_comb begin
    case (alu_op_i)
      ALU_ADD: alu_result = op_a + op_b;
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_XOR: alu_result = op_a ^ op_b;
      // Signed compare
      ALU_SLT: alu_result = {{(REGFILE_WORD_WIDTH-1){1'b0}},
                             ($signed(op_a) < $signed(op_b))};
      ALU_SLL: alu_result = op_a << shamt;
      ALU_SRL: alu_result = op_a >> shamt;
      default: alu_result = '0;
    endcase
  end

  // --------------------------------------------------------------------
  // Result register
  // --------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o <= 1'b0;
      wb_rd_o    <= '0;
      wb_data_o  <= '0;
    end else begin
      // A result for x0 is dropped here
      wb_valid_o <= valid_i && (rd_i != '0);
      if (valid_i) begin
        wb_rd_o   <= rd_i;
        wb_data_o <= alu_result;
      end
    end
  end

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------
  a_wb_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(wb_valid_o));

endmodule

/* rv_int_core.sv */
// ----------------------------------------------------------------------
// Top level of the integer execute core
// Decoder and register file read ports work in the cycle the instruction
// is presented, the execute stage registers the result and writes it
// back through register file port 1 in the next cycle
// Port 0 takes external load returns, read port 2 serves debug reads
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module rv_int_core import rv_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,

  // Instruction input
  input  logic                          instr_valid_i,
  input  logic [31:0]                   instr_i,

  // External write
  input  logic                          ext_we_i,
  input  logic [REGFILE_ADDR_WIDTH-1:0] ext_waddr_i,
  input  logic [REGFILE_WORD_WIDTH-1:0] ext_wdata_i,

  // Debug read
  input  logic [REGFILE_ADDR_WIDTH-1:0] dbg_raddr_i,
  output logic [REGFILE_WORD_WIDTH-1:0] dbg_rdata_o,

  // Writeback visibility
  output logic                          wb_valid_o,
  output logic [REGFILE_ADDR_WIDTH-1:0] wb_rd_o,
  output logic [REGFILE_WORD_WIDTH-1:0] wb_data_o,

  output logic                          illegal_o
);

  // Decoder to execute
  logic [REGFILE_ADDR_WIDTH-1:0] dec_rs1;
  logic [REGFILE_ADDR_WIDTH-1:0] dec_rs2;
  logic [REGFILE_ADDR_WIDTH-1:0] dec_rd;
  logic [ALU_OP_WIDTH-1:0]       dec_alu_op;
  logic                          dec_use_imm;
  logic [REGFILE_WORD_WIDTH-1:0] dec_imm;
  logic                          dec_valid;

  // Register file ports
  logic [REGFILE_ADDR_WIDTH-1:0] rf_raddr [REGFILE_NUM_READ_PORTS];
  logic [REGFILE_WORD_WIDTH-1:0] rf_rdata [REGFILE_NUM_READ_PORTS];
  logic [REGFILE_ADDR_WIDTH-1:0] rf_waddr [REGFILE_NUM_WRITE_PORTS];
  logic [REGFILE_WORD_WIDTH-1:0] rf_wdata [REGFILE_NUM_WRITE_PORTS];
  logic                          rf_we    [REGFILE_NUM_WRITE_PORTS];

  // --------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------
  rv_decoder rv_decoder_i (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_u'(instr_i)),
    .rs1_o         (dec_rs1),
    .rs2_o         (dec_rs2),
    .rd_o          (dec_rd),
    .alu_op_o      (dec_alu_op),
    .use_imm_o     (dec_use_imm),
    .imm_o         (dec_imm),
    .valid_o       (dec_valid),
    .illegal_o     (illegal_o)
  );

  // --------------------------------------------------------------------
  // Execute
  // --------------------------------------------------------------------
  rv_execute_stage rv_execute_stage_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (dec_valid),
    .alu_op_i   (dec_alu_op),
    .use_imm_i  (dec_use_imm),
    .imm_i      (dec_imm),
    .rs1_i      (dec_rs1),
    .rs2_i      (dec_rs2),
    .rd_i       (dec_rd),
    .rs1_data_i (rf_rdata[0]),
    .rs2_data_i (rf_rdata[1]),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

  // --------------------------------------------------------------------
  // Register file
  // --------------------------------------------------------------------
  // Operands on ports 0 and 1, debug on port 2
  assign rf_raddr[0] = dec_rs1;
  assign rf_raddr[1] = dec_rs2;
  assign rf_raddr[2] = dbg_raddr_i;
  assign dbg_rdata_o = rf_rdata[2];

  // External port first so that writeback wins a collision
  assign rf_we[0]    = ext_we_i;
  assign rf_waddr[0] = ext_waddr_i;
  assign rf_wdata[0] = ext_wdata_i;
  assign rf_we[1]    = wb_valid_o;
  assign rf_waddr[1] = wb_rd_o;
  assign rf_wdata[1] = wb_data_o;

  rv_register_file rv_register_file_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .we_i    (rf_we)
  );

  // An illegal word never reaches writeback
  a_illegal_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
    illegal_o |=> !wb_valid_o);

endmodule

/* rv_int_core_stim.txt */
# Columns: W addr data | I instr rd expect | X instr | D addr expect | N
# One command per clock cycle, all values in hex
D 00 00000000
W 00 deadbeef
D 00 00000000
W 01 00000064
W 02 fffffff6
# Immediate forms
I ffb08193 03 0000005f
I ffd12213 04 00000001
I 0ff0c293 05 0000009b
I 7f017313 06 000007f0
I fff06393 07 ffffffff
# Register forms
I 00208433 08 0000005a
I 402084b3 09 0000006e
I 0020f533 0a 00000064
I 0020e5b3 0b fffffff6
I 0020c633 0c ffffff92
I 001126b3 0d 00000001
I 00509733 0e 20000000
I 006157b3 0f 0000ffff
D 0e 20000000
D 0f 0000ffff
# Dependent chain, then a result for x0
I 00108813 10 00000065
I 010808b3 11 000000ca
I 40188933 12 00000066
I 01290033 00 000000cc
I 000949b3 13 00000066
# Writeback and external write hit x20 together
I 12300a13 14 00000123
W 14 00000bad
D 14 00000123
X 0020b3b3
D 07 ffffffff

/* rv_pkg.sv */
// ----------------------------------------------------------------------
// Shared definitions for the integer execute core
// Register file geometry, instruction field codes, ALU operation codes
// and the instruction word union read by the decoder
// Modules pull these in with a wildcard import in their header
// ----------------------------------------------------------------------

package rv_pkg;

  // --------------------------------------------------------------------
  // Register file
  // --------------------------------------------------------------------
  localparam int REGFILE_NUM_WORDS       = 32;
  localparam int REGFILE_WORD_WIDTH      = 32;
  localparam int REGFILE_ADDR_WIDTH      = 5;
  // Ports 0 and 1 feed the operands, port 2 is the debug port
  localparam int REGFILE_NUM_READ_PORTS  = 3;
  // Port 0 is the external load-return port, port 1 is writeback
  localparam int REGFILE_NUM_WRITE_PORTS = 2;

  // --------------------------------------------------------------------
  // Instruction fields
  // --------------------------------------------------------------------
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRL     = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  // Base encoding, and the alternate one that turns ADD into SUB
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  // --------------------------------------------------------------------
  // ALU operations
  // --------------------------------------------------------------------
  localparam int ALU_OP_WIDTH = 4;

  localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD = 4'd0;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB = 4'd1;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_AND = 4'd2;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OR  = 4'd3;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR = 4'd4;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLT = 4'd5;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLL = 4'd6;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SRL = 4'd7;

  // --------------------------------------------------------------------
  // Instruction word, seen as register form or immediate form
  // --------------------------------------------------------------------
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_u;

endpackage

/* rv_register_file.sv */
// ----------------------------------------------------------------------
// Flip-flop register file, 32 words of 32 bits
// Three combinational read ports and two write ports
// Register x0 is tied to zero and ignores writes
// When both write ports hit one register, the higher port wins
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module rv_register_file import rv_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,

  // Read ports
  input  logic [REGFILE_ADDR_WIDTH-1:0] raddr_i [REGFILE_NUM_READ_PORTS],
  output logic [REGFILE_WORD_WIDTH-1:0] rdata_o [REGFILE_NUM_READ_PORTS],

  // Write ports
  input  logic [REGFILE_ADDR_WIDTH-1:0] waddr_i [REGFILE_NUM_WRITE_PORTS],
  input  logic [REGFILE_WORD_WIDTH-1:0] wdata_i [REGFILE_NUM_WRITE_PORTS],
  input  logic                          we_i    [REGFILE_NUM_WRITE_PORTS]
);

  // Storage, entry 0 is a constant
  logic [REGFILE_WORD_WIDTH-1:0] mem [REGFILE_NUM_WORDS];

  // One-hot write enables, one vector per write port
  logic [REGFILE_NUM_WORDS-1:0]  we_dec [REGFILE_NUM_WRITE_PORTS];

  // --------------------------------------------------------------------
  // Read side
  // --------------------------------------------------------------------
  for (genvar r = 0; r < REGFILE_NUM_READ_PORTS; r++) begin : gen_rdata
    assign rdata_o[r] = mem[raddr_i[r]];
  end

  // --------------------------------------------------------------------
  // Write address decoder
  // --------------------------------------------------------------------
  for (genvar p = 0; p < REGFILE_NUM_WRITE_PORTS; p++) begin : gen_we_port
    for (genvar w = 0; w < REGFILE_NUM_WORDS; w++) begin : gen_we_word
      assign we_dec[p][w] = we_i[p] && (waddr_i[p] == w);
    end
  end

  // --------------------------------------------------------------------
  // Storage update
  // --------------------------------------------------------------------
  for (genvar w = 0; w < REGFILE_NUM_WORDS; w++) begin : gen_rf
    if (w == 0) begin : gen_zero
      // x0 has no storage
      assign mem[w] = '0;
    end else begin : gen_reg
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          mem[w] <= '0;
        end else begin
          // Later ports overwrite earlier ones in the same cycle
          for (int p = 0; p < REGFILE_NUM_WRITE_PORTS; p++) begin
            if (we_dec[p][w]) begin
              mem[w] <= wdata_i[p];
            end
          end
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------
  // Reading x0 gives zero on every port, even right after a write to it
  for (genvar r = 0; r < REGFILE_NUM_READ_PORTS; r++) begin : gen_chk_x0
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (raddr_i[r] == '0) |-> (rdata_o[r] == '0));
  end

  // Colliding writes leave the port 1 data in the register
  a_port1_wins: assert property (@(posedge clk) disable iff (!rst_n)
    (we_i[0] && we_i[1] && (waddr_i[0] == waddr_i[1]) && (waddr_i[1] != '0))
    |=> (mem[$past(waddr_i[1])] == $past(wdata_i[1])));

endmodule

/* tb_clk_gen.sv */
// ----------------------------------------------------------------------
// Clock and reset source for the integer core testbench
// 20 ns clock, reset held low over the first two rising edges
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Half period of 10 ns
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release just after the second edge, away from the clock
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

/* tb_rv_int_core.sv */
// ----------------------------------------------------------------------
// Testbench for the integer execute core
// Reads one command per cycle from the stimulus file, drives the DUT
// 1 ns after the rising edge and checks outputs at the falling edge
// Writeback of an instruction is checked in the following cycle
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_rv_int_core import rv_pkg::*; ;

  logic                          clk;
  logic                          rst_n;
  logic                          instr_valid;
  logic [31:0]                   instr;
  logic                          ext_we;
  logic [REGFILE_ADDR_WIDTH-1:0] ext_waddr;
  logic [REGFILE_WORD_WIDTH-1:0] ext_wdata;
  logic [REGFILE_ADDR_WIDTH-1:0] dbg_raddr;
  logic [REGFILE_WORD_WIDTH-1:0] dbg_rdata;
  logic                          wb_valid;
  logic [REGFILE_ADDR_WIDTH-1:0] wb_rd;
  logic [REGFILE_WORD_WIDTH-1:0] wb_data;
  logic                          illegal;

  // Parsed commands and their operands
  logic [7:0]  cmd_q  [$];
  logic [31:0] arg0_q [$];
  logic [31:0] arg1_q [$];
  logic [31:0] arg2_q [$];

  // Writeback expected in the current cycle
  logic        exp_valid;
  logic [4:0]  exp_rd;
  logic [31:0] exp_data;

  int cycle_cnt   = 0;
  int cycle_limit = 0;

  tb_clk_gen tb_clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rv_int_core rv_int_core_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .ext_we_i      (ext_we),
    .ext_waddr_i   (ext_waddr),
    .ext_wdata_i   (ext_wdata),
    .dbg_raddr_i   (dbg_raddr),
    .dbg_rdata_o   (dbg_rdata),
    .wb_valid_o    (wb_valid),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data),
    .illegal_o     (illegal)
  );

  // ----------------------------------------------------------------------
  // Failure handling and checks
  // ----------------------------------------------------------------------
  task automatic stop_with_failure();
    $display("TB FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at time %0t: %s, got %h, expected %h",
               $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  // Writeback from the previous command
  task automatic check_writeback(input int idx);
    check_value(wb_valid, exp_valid, $sformatf("command %0d wb_valid_o", idx));
    if (exp_valid) begin
      check_value(wb_rd, exp_rd, $sformatf("command %0d wb_rd_o", idx));
      check_value(wb_data, exp_data, $sformatf("command %0d wb_data_o", idx));
    end
  endtask

  task automatic drive_idle();
    instr_valid = 1'b0;
    instr       = '0;
    ext_we      = 1'b0;
    ext_waddr   = '0;
    ext_wdata   = '0;
    dbg_raddr   = '0;
  endtask

  // Every register reads zero straight out of reset
  task automatic queue_reset_reads();
    for (int r = 0; r < REGFILE_NUM_WORDS; r++) begin
      cmd_q.push_back("D");
      arg0_q.push_back(r);
      arg1_q.push_back(32'd0);
      arg2_q.push_back(32'd0);
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus file reader that skips lines starting with #
  // ----------------------------------------------------------------------
  task automatic load_stimulus();
    int                fd;
    int                code;
    logic [7:0]        cmd;
    logic [31:0]       a0;
    logic [31:0]       a1;
    logic [31:0]       a2;
    logic [8*128-1:0]  rest;
    fd = $fopen("rv_int_core_stim.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open stimulus file rv_int_core_stim.txt");
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", cmd);
      if (code != 1) break;
      a0 = '0;
      a1 = '0;
      a2 = '0;
      case (cmd)
        "#":      code = $fgets(rest, fd);
        "W", "D": code = $fscanf(fd, "%h %h", a0, a1);
        "I":      code = $fscanf(fd, "%h %h %h", a0, a1, a2);
        "X":      code = $fscanf(fd, "%h", a0);
        "N":      code = 0;
        default: begin
          $display("ERROR: unknown command '%c' in stimulus file", cmd);
          stop_with_failure();
        end
      endcase
      if (cmd != "#") begin
        cmd_q.push_back(cmd);
        arg0_q.push_back(a0);
        arg1_q.push_back(a1);
        arg2_q.push_back(a2);
      end
    end
    $fclose(fd);
  endtask

  // Run limit scales with the number of commands
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("ERROR: simulation timed out after %0d cycles", cycle_cnt);
      stop_with_failure();
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [7:0] cmd;
    drive_idle();
    exp_valid = 1'b0;
    exp_rd    = '0;
    exp_data  = '0;
    queue_reset_reads();
    load_stimulus();
    cycle_limit = 4 * cmd_q.size() + 20;
    wait (rst_n === 1'b1);

    for (int k = 0; k < cmd_q.size(); k++) begin
      cmd = cmd_q[k];
      @(posedge clk);
      #1;
      drive_idle();
      case (cmd)
        "W": begin
          ext_we    = 1'b1;
          ext_waddr = arg0_q[k][4:0];
          ext_wdata = arg1_q[k];
        end
        "I", "X": begin
          instr_valid = 1'b1;
          instr       = arg0_q[k];
        end
        "D": dbg_raddr = arg0_q[k][4:0];
        default: ;
      endcase

      @(negedge clk);
      check_writeback(k);
      // Illegal pulse only for X lines
      check_value(illegal, (cmd == "X"), $sformatf("command %0d illegal_o", k));
      if (cmd == "D") begin
        check_value(dbg_rdata, arg1_q[k], $sformatf("command %0d debug read", k));
      end

      // A result for x0 never shows up on the writeback bus
      exp_valid = (cmd == "I") && (arg1_q[k][4:0] != 5'd0);
      exp_rd    = arg1_q[k][4:0];
      exp_data  = arg2_q[k];
    end

    // Last writeback if there is one
    @(posedge clk);
    #1;
    drive_idle();
    @(negedge clk);
    check_writeback(cmd_q.size());

    $display("TB PASSED");
    $finish;
  end

endmodule
